// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing -f compile.f --top-module tbPipelinedCla32 \
		-Mdir obj_dir -o simv

run: compile
	./obj_dir/simv | tee sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
hw/claPkg.sv
hw/claStageIf.sv
hw/pgStage.sv
hw/lookaheadStage.sv
hw/sumStage.sv
hw/pipelinedCla32.sv
testbench/tbClock.sv
testbench/tbPipelinedCla32.sv

// ==== hw/claPkg.sv ====
package claPkg;

  // Operand width
  localparam int dataWidth = 32;

  // Bits per lookahead group
  localparam int groupWidth = 4;

  // Number of 4-bit groups in one operand
  localparam int numGroups = dataWidth / groupWidth;

  // Groups collected into one 16-bit block
  localparam int groupsPerBlock = 4;

  // Number of 16-bit blocks
  localparam int numBlocks = numGroups / groupsPerBlock;

endpackage

// ==== hw/claStageIf.sv ====
`timescale 1ns/1ps

// Propagate/generate terms from the first stage
interface pgIf import claPkg::*; ();
  logic                 valid;
  logic [dataWidth-1:0] bitP;
  logic [dataWidth-1:0] bitG;
  logic [numGroups-1:0] groupP;
  logic [numGroups-1:0] groupG;
  logic                 cin;
  logic                 signA;
  logic                 signB;

  modport source (
    output valid, bitP, bitG, groupP, groupG, cin, signA, signB
  );

  modport sink (
    input valid, bitP, bitG, groupP, groupG, cin, signA, signB
  );
endinterface

// Resolved group carries from the second stage
interface carryIf import claPkg::*; ();
  logic                 valid;
  logic [dataWidth-1:0] bitP;
  logic [dataWidth-1:0] bitG;
  logic [numGroups-1:0] groupCarry;
  logic                 cout;
  logic                 signA;
  logic                 signB;

  modport source (
    output valid, bitP, bitG, groupCarry, cout, signA, signB
  );

  modport sink (
    input valid, bitP, bitG, groupCarry, cout, signA, signB
  );
endinterface

// ==== hw/lookaheadStage.sv ====
`timescale 1ns/1ps

module lookaheadStage import claPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  pgIf.sink      pgIn,
  carryIf.source carryOut
);

  logic [numBlocks-1:0] blockP;
  logic [numBlocks-1:0] blockG;
  logic [numBlocks-1:0] blockCin;
  logic [numGroups-1:0] groupCarry;
  logic                 cout;

  // Block propagate and generate from the four group terms
  always_comb begin
    int base;
    for (int k = 0; k < numBlocks; k++) begin
      base = k * groupsPerBlock;
      blockP[k] = &pgIn.groupP[base +: groupsPerBlock];
      blockG[k] = pgIn.groupG[base+3]
                ^ (pgIn.groupP[base+3] & pgIn.groupG[base+2])
                ^ (pgIn.groupP[base+3] & pgIn.groupP[base+2] & pgIn.groupG[base+1])
                ^ (pgIn.groupP[base+3] & pgIn.groupP[base+2] & pgIn.groupP[base+1]
                   & pgIn.groupG[base]);
    end
  end

  // Carries between the two blocks and out of the top one
  assign blockCin[0] = pgIn.cin;
  assign blockCin[1] = blockG[0] ^ (blockP[0] & blockCin[0]);
  assign cout        = blockG[1] ^ (blockP[1] & blockCin[1]);

  // Expand each block carry-in into its four group carries
  always_comb begin
    int base;
    logic c0;
    for (int k = 0; k < numBlocks; k++) begin
      base = k * groupsPerBlock;
      c0   = blockCin[k];
      groupCarry[base]   = c0;
      groupCarry[base+1] = pgIn.groupG[base] ^ (pgIn.groupP[base] & c0);
      groupCarry[base+2] = pgIn.groupG[base+1]
                         ^ (pgIn.groupP[base+1] & pgIn.groupG[base])
                         ^ (pgIn.groupP[base+1] & pgIn.groupP[base] & c0);
      groupCarry[base+3] = pgIn.groupG[base+2]
                         ^ (pgIn.groupP[base+2] & pgIn.groupG[base+1])
                         ^ (pgIn.groupP[base+2] & pgIn.groupP[base+1] & pgIn.groupG[base])
                         ^ (pgIn.groupP[base+2] & pgIn.groupP[base+1] & pgIn.groupP[base]
                            & c0);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      carryOut.valid <= 1'b0;
    end else begin
      carryOut.valid <= pgIn.valid;
    end
  end

  always_ff @(posedge clk) begin
    carryOut.bitP       <= pgIn.bitP;
    carryOut.bitG       <= pgIn.bitG;
    carryOut.groupCarry <= groupCarry;
    carryOut.cout       <= cout;
    carryOut.signA      <= pgIn.signA;
    carryOut.signB      <= pgIn.signB;
  end

endmodule

// ==== hw/pgStage.sv ====
`timescale 1ns/1ps

module pgStage import claPkg::*; (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 inValid,
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  input  logic                 cin,
  pgIf.source                  pgOut
);

  logic [dataWidth-1:0] p;
  logic [dataWidth-1:0] g;
  logic [numGroups-1:0] groupP;
  logic [numGroups-1:0] groupG;

  assign p = a ^ b;
  assign g = a & b;

  // Group terms, bit 3 of each group is the most significant
  always_comb begin
    int base;
    for (int i = 0; i < numGroups; i++) begin
      base = i * groupWidth;
      groupP[i] = &p[base +: groupWidth];
      groupG[i] = g[base+3]
                ^ (p[base+3] & g[base+2])
                ^ (p[base+3] & p[base+2] & g[base+1])
                ^ (p[base+3] & p[base+2] & p[base+1] & g[base]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pgOut.valid <= 1'b0;
    end else begin
      pgOut.valid <= inValid;
    end
  end

  // Payload moves every cycle, valid qualifies it
  always_ff @(posedge clk) begin
    pgOut.bitP   <= p;
    pgOut.bitG   <= g;
    pgOut.groupP <= groupP;
    pgOut.groupG <= groupG;
    pgOut.cin    <= cin;
    pgOut.signA  <= a[dataWidth-1];
    pgOut.signB  <= b[dataWidth-1];
  end

endmodule

// ==== hw/pipelinedCla32.sv ====
`timescale 1ns/1ps

module pipelinedCla32 import claPkg::*; (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 inValid,
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  input  logic                 cin,
  output logic                 outValid,
  output logic [dataWidth-1:0] sum,
  output logic                 cout,
  output logic                 overflow
);

  pgIf    pgBus ();
  carryIf carryBus ();

  // Stage 1 bit and group propagate/generate
  pgStage pgStageInst (
    .clk     (clk),
    .rstN    (rstN),
    .inValid (inValid),
    .a       (a),
    .b       (b),
    .cin     (cin),
    .pgOut   (pgBus.source)
  );

  // Stage 2 block and group carries
  lookaheadStage lookaheadStageInst (
    .clk      (clk),
    .rstN     (rstN),
    .pgIn     (pgBus.sink),
    .carryOut (carryBus.source)
  );

  // Stage 3 bit carries, sum and flags
  sumStage sumStageInst (
    .clk      (clk),
    .rstN     (rstN),
    .carryIn  (carryBus.sink),
    .outValid (outValid),
    .sum      (sum),
    .cout     (cout),
    .overflow (overflow)
  );

endmodule

// ==== hw/sumStage.sv ====
`timescale 1ns/1ps

module sumStage import claPkg::*; (
  input  logic                 clk,
  input  logic                 rstN,
  carryIf.sink                 carryIn,
  output logic                 outValid,
  output logic [dataWidth-1:0] sum,
  output logic                 cout,
  output logic                 overflow
);

  logic [dataWidth-1:0] bitCarry;
  logic [dataWidth-1:0] nextSum;
  logic                 nextOverflow;

  // Four bit carries per group from its group carry
  always_comb begin
    int base;
    logic c0;
    logic [groupWidth-1:0] p;
    logic [groupWidth-1:0] g;
    for (int i = 0; i < numGroups; i++) begin
      base = i * groupWidth;
      c0   = carryIn.groupCarry[i];
      p    = carryIn.bitP[base +: groupWidth];
      g    = carryIn.bitG[base +: groupWidth];
      bitCarry[base]   = c0;
      bitCarry[base+1] = g[0] ^ (p[0] & c0);
      bitCarry[base+2] = g[1] ^ (p[1] & g[0]) ^ (p[1] & p[0] & c0);
      bitCarry[base+3] = g[2] ^ (p[2] & g[1]) ^ (p[2] & p[1] & g[0]) ^ (p[2] & p[1] & p[0] & c0);
    end
  end

  assign nextSum = carryIn.bitP ^ bitCarry;

  // Same operand signs but a different result sign
  assign nextOverflow = (carryIn.signA == carryIn.signB)
                     && (nextSum[dataWidth-1] != carryIn.signA);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= carryIn.valid;
    end
  end

  always_ff @(posedge clk) begin
    sum      <= nextSum;
    cout     <= carryIn.cout;
    overflow <= nextOverflow;
  end

endmodule

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic rstN
);

  localparam int halfPeriod  = 4;
  localparam int resetCycles = 10;

  initial begin
    clk = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

  // Release lands just after an edge, like the other inputs
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1 rstN = 1'b1;
  end

endmodule

// ==== testbench/tbPipelinedCla32.sv ====
`timescale 1ns/1ps

module tbPipelinedCla32 import claPkg::*; ();

  localparam int unsigned randomSeed = 32'hdc1d_ffbc;
  localparam int timeoutCycles = 50;
  localparam int latency = 3;

  typedef struct packed {
    logic [dataWidth-1:0] sumVal;
    logic                 coutVal;
    logic                 overflowVal;
  } expectedResult;

  logic                 clk;
  logic                 rstN;
  logic                 testRstN;
  logic                 dutRstN;
  logic                 inValid;
  logic [dataWidth-1:0] a;
  logic [dataWidth-1:0] b;
  logic                 cin;
  logic                 outValid;
  logic [dataWidth-1:0] sum;
  logic                 cout;
  logic                 overflow;

  logic [latency-1:0] validPipe;
  expectedResult      expQ[$];
  string              testName;
  bit                 monitorOn;
  int                 errorCount;
  int                 timeoutCount;
  int                 unexpectedCount;
  int                 resultCount;

  tbClock clockGen (
    .clk  (clk),
    .rstN (rstN)
  );

  assign dutRstN = rstN & testRstN;

  pipelinedCla32 UUT (
    .clk      (clk),
    .rstN     (dutRstN),
    .inValid  (inValid),
    .a        (a),
    .b        (b),
    .cin      (cin),
    .outValid (outValid),
    .sum      (sum),
    .cout     (cout),
    .overflow (overflow)
  );

  // 33-bit sum and the sign rule for overflow
  function automatic expectedResult modelAdd(input logic [dataWidth-1:0] opA,
                                             input logic [dataWidth-1:0] opB,
                                             input logic carryIn);
    logic [dataWidth:0] full;
    expectedResult      res;
    full = {1'b0, opA} + {1'b0, opB} + {{dataWidth{1'b0}}, carryIn};
    res.sumVal = full[dataWidth-1:0];
    res.coutVal = full[dataWidth];
    res.overflowVal = (opA[dataWidth-1] == opB[dataWidth-1])
                   && (full[dataWidth-1] != opA[dataWidth-1]);
    return res;
  endfunction

  task automatic checkSum(input string name, input logic [dataWidth-1:0] expected,
                          input logic [dataWidth-1:0] actual);
    if (actual !== expected) begin
      $display("error: test %s expected %h actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("error: test %s expected %b actual %b", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkCount(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("error: test %s expected %0d actual %0d", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic stepCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic driveItem(input logic [dataWidth-1:0] opA, input logic [dataWidth-1:0] opB,
                           input logic carryIn);
    inValid = 1'b1;
    a = opA;
    b = opB;
    cin = carryIn;
    expQ.push_back(modelAdd(opA, opB, carryIn));
  endtask

  task automatic driveRandom();
    driveItem($urandom(), $urandom(), 1'($urandom_range(0, 1)));
  endtask

  task automatic idleInput();
    inValid = 1'b0;
    a = '0;
    b = '0;
    cin = 1'b0;
  endtask

  task automatic drainPipe();
    int cycles;
    cycles = 0;
    while (expQ.size() > 0 && cycles < timeoutCycles) begin
      stepCycle();
      cycles++;
    end
    if (expQ.size() > 0) begin
      $display("timeout: %0d results never arrived in test %s", expQ.size(), testName);
      timeoutCount++;
      expQ.delete();
    end
  endtask

  // Drive one item and count edges until its result shows up
  task automatic runSingle(input logic [dataWidth-1:0] opA, input logic [dataWidth-1:0] opB,
                           input logic carryIn);
    int cycles;
    logic seen;
    driveItem(opA, opB, carryIn);
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < timeoutCycles) begin
      stepCycle();
      cycles++;
      idleInput();
      @(negedge clk);
      seen = outValid;
    end
    if (!seen) begin
      $display("timeout: outValid never rose in test %s", testName);
      timeoutCount++;
    end else begin
      checkCount({testName, " latency"}, latency, cycles);
    end
    stepCycle();
    drainPipe();
  endtask

  task automatic waitForReset();
    int cycles;
    cycles = 0;
    while (!rstN && cycles < timeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!rstN) begin
      $display("timeout: reset was never released");
      timeoutCount++;
    end
    stepCycle();
    checkFlag("reset outValid", 1'b0, outValid);
    monitorOn = 1'b1;
  endtask

  task automatic testBasic();
    testName = "basic";
    runSingle(32'h0, 32'h0, 1'b0);
    runSingle(32'h3, 32'h5, 1'b0);
    runSingle(32'd100, 32'd23, 1'b1);
    runSingle(32'h0, 32'h0, 1'b1);
    runSingle(32'h7, 32'h9, 1'b1);
  endtask

  task automatic testCarryChain();
    testName = "carryChain";
    runSingle(32'hffff_ffff, 32'h0, 1'b1);
    runSingle(32'hffff_ffff, 32'h1, 1'b0);
    runSingle(32'h0000_000f, 32'h1, 1'b0);
    runSingle(32'h0000_ffff, 32'h1, 1'b0);
    runSingle(32'h0000_ffff, 32'h0, 1'b1);
    runSingle(32'hffff_0000, 32'h0001_0000, 1'b0);
    runSingle(32'h00ff_ffff, 32'h0, 1'b1);
  endtask

  task automatic testOverflow();
    testName = "overflow";
    runSingle(32'h7fff_ffff, 32'h1, 1'b0);
    runSingle(32'h8000_0000, 32'h8000_0000, 1'b0);
    runSingle(32'h4000_0000, 32'h4000_0000, 1'b0);
    runSingle(32'h7fff_ffff, 32'h8000_0000, 1'b1);
    runSingle(32'hffff_ffff, 32'h1, 1'b0);
    runSingle(32'h8000_0000, 32'hffff_ffff, 1'b0);
  endtask

  task automatic testStream();
    testName = "stream";
    resultCount = 0;
    for (int i = 0; i < 200; i++) begin
      driveRandom();
      stepCycle();
    end
    idleInput();
    drainPipe();
    checkCount("stream results", 200, resultCount);
  endtask

  task automatic testGaps();
    int gap;
    testName = "gaps";
    resultCount = 0;
    for (int i = 0; i < 60; i++) begin
      driveRandom();
      stepCycle();
      idleInput();
      gap = $urandom_range(0, 4);
      repeat (gap) stepCycle();
    end
    drainPipe();
    checkCount("gaps results", 60, resultCount);
  endtask

  // Two items still inside the pipe when reset hits
  task automatic testResetInFlight();
    testName = "resetInFlight";
    driveRandom();
    stepCycle();
    driveRandom();
    stepCycle();
    idleInput();
    testRstN = 1'b0;
    expQ.delete();
    stepCycle();
    // The first item would leave the pipe at this edge
    checkFlag("resetInFlight outValid", 1'b0, outValid);
    repeat (2) stepCycle();
    testRstN = 1'b1;
    repeat (8) stepCycle();
    runSingle(32'h1234_5678, 32'h0fed_cba9, 1'b1);
  endtask

  // Reference valid pipe three registers deep
  always @(posedge clk) begin
    if (!dutRstN) begin
      validPipe <= '0;
    end else begin
      validPipe <= {validPipe[latency-2:0], inValid};
    end
  end

  always @(negedge clk) begin
    expectedResult expItem;
    if (monitorOn) begin
      checkFlag({testName, " outValid"}, validPipe[latency-1], outValid);
      if (outValid) begin
        if (expQ.size() == 0) begin
          $display("unexpected result %h arrived with nothing pending in test %s",
                   sum, testName);
          unexpectedCount++;
        end else begin
          expItem = expQ.pop_front();
          checkSum({testName, " sum"}, expItem.sumVal, sum);
          checkFlag({testName, " cout"}, expItem.coutVal, cout);
          checkFlag({testName, " overflow"}, expItem.overflowVal, overflow);
          resultCount++;
        end
      end
    end
  end

  initial begin
    inValid = 1'b0;
    a = '0;
    b = '0;
    cin = 1'b0;
    testRstN = 1'b1;
    validPipe = '0;
    monitorOn = 1'b0;
    errorCount = 0;
    timeoutCount = 0;
    unexpectedCount = 0;
    resultCount = 0;
    testName = "reset";
    void'($urandom(randomSeed));

    waitForReset();
    testBasic();
    testCarryChain();
    testOverflow();
    testStream();
    testGaps();
    testResetInFlight();

    $display("errors: %0d value, %0d timeout, %0d unexpected",
             errorCount, timeoutCount, unexpectedCount);
    if (errorCount + timeoutCount + unexpectedCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
